// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rrf_top
FILELIST  = rrf_top.f
PASS_MSG  = Simulation completed successfully
BIN       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: rrf_bank.sv
`timescale 1ns/100ps

module rrf_bank (
  input  logic                clk,
  input  logic                rst,
  input  rrf_pkg::rrf_entry_t write0_entry,
  input  rrf_pkg::rrf_entry_t write1_entry,
  input  rrf_pkg::rrf_entry_t write2_entry,
  input  rrf_pkg::rrf_data_t  write0_data,
  input  rrf_pkg::rrf_data_t  write1_data,
  input  rrf_pkg::rrf_data_t  write2_data,
  input  logic                write0_en,
  input  logic                write1_en,
  input  logic                write2_en,
  input  logic                write_thread,
  input  logic                read_thread,
  input  rrf_pkg::rrf_entry_t read0_entry,
  input  rrf_pkg::rrf_entry_t read1_entry,
  input  rrf_pkg::rrf_entry_t read2_entry,
  input  rrf_pkg::rrf_entry_t read3_entry,
  output rrf_pkg::rrf_data_t  read0_data,
  output rrf_pkg::rrf_data_t  read1_data,
  output rrf_pkg::rrf_data_t  read2_data,
  output rrf_pkg::rrf_data_t  read3_data
);

  import rrf_pkg::*;

  rrf_data_t entry_data [RRF_ENTRIES_PER_TILE];

  generate
    for (genvar i = 0; i < RRF_ENTRIES_PER_TILE; i++)
    begin : entry_gen
      rrf_entry #(
        .INDEX(i)
      ) entry_i (
        .clk          (clk),
        .rst          (rst),
        .write0_entry (write0_entry),
        .write1_entry (write1_entry),
        .write2_entry (write2_entry),
        .write0_data  (write0_data),
        .write1_data  (write1_data),
        .write2_data  (write2_data),
        .write0_en    (write0_en),
        .write1_en    (write1_en),
        .write2_en    (write2_en),
        .write_thread (write_thread),
        .read_thread  (read_thread),
        .entry_data   (entry_data[i])
      );
    end
  endgenerate

  // Read mux per port replaces the old tristate bus.
  assign read0_data = entry_data[read0_entry];
  assign read1_data = entry_data[read1_entry];
  assign read2_data = entry_data[read2_entry];
  assign read3_data = entry_data[read3_entry];

endmodule

// File: rrf_entry.sv
`timescale 1ns/100ps

module rrf_entry #(
  parameter int INDEX = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  rrf_pkg::rrf_entry_t write0_entry,
  input  rrf_pkg::rrf_entry_t write1_entry,
  input  rrf_pkg::rrf_entry_t write2_entry,
  input  rrf_pkg::rrf_data_t  write0_data,
  input  rrf_pkg::rrf_data_t  write1_data,
  input  rrf_pkg::rrf_data_t  write2_data,
  input  logic                write0_en,
  input  logic                write1_en,
  input  logic                write2_en,
  input  logic                write_thread,
  input  logic                read_thread,
  output rrf_pkg::rrf_data_t  entry_data
);

  import rrf_pkg::*;

  rrf_data_t                  copy_q [RRF_THREADS]; // One value per thread.
  logic [RRF_WRITE_PORTS-1:0] hit;
  rrf_data_t                  wdata;

  assign hit[0] = write0_en && write0_entry == rrf_entry_t'(INDEX);
  assign hit[1] = write1_en && write1_entry == rrf_entry_t'(INDEX);
  assign hit[2] = write2_en && write2_entry == rrf_entry_t'(INDEX);

  // AND-OR select, at most one hit.
  assign wdata = ({RRF_DATA_WIDTH{hit[0]}} & write0_data)
               | ({RRF_DATA_WIDTH{hit[1]}} & write1_data)
               | ({RRF_DATA_WIDTH{hit[2]}} & write2_data);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int t = 0; t < RRF_THREADS; t++)
        copy_q[t] <= '0;
    end
    else if (|hit)
      copy_q[write_thread] <= wdata;
  end

  assign entry_data = copy_q[read_thread];

  // Relies on the decode priority upstream.
  a_single_writer: assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
    else $error("Entry %0d hit by several write ports", INDEX);

endmodule

// File: rrf_pkg.sv
package rrf_pkg;

  // Register value width.
  localparam int RRF_DATA_WIDTH = 32;

  // Full address is tile field over entry index.
  localparam int RRF_ADDR_WIDTH = 6;
  localparam int RRF_ENTRY_BITS = 4;
  localparam int RRF_ENTRIES_PER_TILE = 16;

  // Tile field values 2 and 3 name no tile.
  localparam int RRF_TILE_COUNT = 2;

  localparam int RRF_READ_PORTS = 4;
  localparam int RRF_WRITE_PORTS = 3;
  localparam int RRF_THREADS = 2;

  // Register value.
  typedef logic [RRF_DATA_WIDTH-1:0] rrf_data_t;

  // Full register address.
  typedef logic [RRF_ADDR_WIDTH-1:0] rrf_addr_t;

  // Entry index within a tile.
  typedef logic [RRF_ENTRY_BITS-1:0] rrf_entry_t;

  // Tile field of an address.
  typedef logic [RRF_ADDR_WIDTH-RRF_ENTRY_BITS-1:0] rrf_tile_t;

  // One bit per existing tile.
  typedef logic [RRF_TILE_COUNT-1:0] rrf_tile_mask_t;

endpackage

// File: rrf_read_stage.sv
`timescale 1ns/100ps

module rrf_read_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                read_clk_en,
  input  logic                read_thread,
  input  rrf_pkg::rrf_addr_t  read0_addr,
  input  rrf_pkg::rrf_addr_t  read1_addr,
  input  rrf_pkg::rrf_addr_t  read2_addr,
  input  rrf_pkg::rrf_addr_t  read3_addr,
  input  logic                read0_oe,
  input  logic                read1_oe,
  input  logic                read2_oe,
  input  logic                read3_oe,
  output logic                read_thread_q,
  output rrf_pkg::rrf_entry_t read0_entry,
  output rrf_pkg::rrf_entry_t read1_entry,
  output rrf_pkg::rrf_entry_t read2_entry,
  output rrf_pkg::rrf_entry_t read3_entry,
  input  rrf_pkg::rrf_data_t  bank0_read0_data,
  input  rrf_pkg::rrf_data_t  bank0_read1_data,
  input  rrf_pkg::rrf_data_t  bank0_read2_data,
  input  rrf_pkg::rrf_data_t  bank0_read3_data,
  input  rrf_pkg::rrf_data_t  bank1_read0_data,
  input  rrf_pkg::rrf_data_t  bank1_read1_data,
  input  rrf_pkg::rrf_data_t  bank1_read2_data,
  input  rrf_pkg::rrf_data_t  bank1_read3_data,
  output rrf_pkg::rrf_data_t  read0_data,
  output rrf_pkg::rrf_data_t  read1_data,
  output rrf_pkg::rrf_data_t  read2_data,
  output rrf_pkg::rrf_data_t  read3_data
);

  import rrf_pkg::*;

  rrf_addr_t [RRF_READ_PORTS-1:0] addr_q;
  logic [RRF_READ_PORTS-1:0]      oe_q;
  logic                           thread_q;
  rrf_data_t                      bank_data [RRF_TILE_COUNT][RRF_READ_PORTS];
  rrf_data_t                      data_out [RRF_READ_PORTS];

  // Request registers, frozen while read_clk_en is low.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr_q <= '0;
      oe_q <= '1; // Outputs enabled out of reset.
      thread_q <= 1'b0;
    end
    else if (read_clk_en)
    begin
      addr_q <= {read3_addr, read2_addr, read1_addr, read0_addr};
      oe_q <= {read3_oe, read2_oe, read1_oe, read0_oe};
      thread_q <= read_thread;
    end
  end

  assign read_thread_q = thread_q;
  assign read0_entry = addr_q[0][RRF_ENTRY_BITS-1:0];
  assign read1_entry = addr_q[1][RRF_ENTRY_BITS-1:0];
  assign read2_entry = addr_q[2][RRF_ENTRY_BITS-1:0];
  assign read3_entry = addr_q[3][RRF_ENTRY_BITS-1:0];

  assign bank_data[0] = '{bank0_read0_data, bank0_read1_data, bank0_read2_data, bank0_read3_data};
  assign bank_data[1] = '{bank1_read0_data, bank1_read1_data, bank1_read2_data, bank1_read3_data};

  // Zero unless oe is set and the tile exists.
  always_comb
  begin
    rrf_tile_t tile;
    for (int p = 0; p < RRF_READ_PORTS; p++)
    begin
      tile = addr_q[p][RRF_ADDR_WIDTH-1:RRF_ENTRY_BITS];
      data_out[p] = '0;
      for (int t = 0; t < RRF_TILE_COUNT; t++)
      begin
        if (oe_q[p] && tile == rrf_tile_t'(t))
          data_out[p] = bank_data[t][p];
      end
    end
  end

  assign read0_data = data_out[0];
  assign read1_data = data_out[1];
  assign read2_data = data_out[2];
  assign read3_data = data_out[3];

  a_req_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({addr_q, oe_q, thread_q}))
    else $error("Read request registers hold unknown bits");

endmodule

// File: rrf_top.f
rrf_pkg.sv
rrf_write_decode.sv
rrf_entry.sv
rrf_bank.sv
rrf_read_stage.sv
rrf_top.sv
tb_rrf_top.sv

// File: rrf_top.sv
`timescale 1ns/100ps

module rrf_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               read_clk_en,
  input  logic               read_thread,
  input  rrf_pkg::rrf_addr_t read0_addr,
  input  rrf_pkg::rrf_addr_t read1_addr,
  input  rrf_pkg::rrf_addr_t read2_addr,
  input  rrf_pkg::rrf_addr_t read3_addr,
  input  logic               read0_oe,
  input  logic               read1_oe,
  input  logic               read2_oe,
  input  logic               read3_oe,
  output rrf_pkg::rrf_data_t read0_data,
  output rrf_pkg::rrf_data_t read1_data,
  output rrf_pkg::rrf_data_t read2_data,
  output rrf_pkg::rrf_data_t read3_data,
  input  logic               write_thread,
  input  rrf_pkg::rrf_addr_t write0_addr,
  input  rrf_pkg::rrf_addr_t write1_addr,
  input  rrf_pkg::rrf_addr_t write2_addr,
  input  rrf_pkg::rrf_data_t write0_data,
  input  rrf_pkg::rrf_data_t write1_data,
  input  rrf_pkg::rrf_data_t write2_data,
  input  logic               write0_wen,
  input  logic               write1_wen,
  input  logic               write2_wen
);

  import rrf_pkg::*;

  rrf_tile_mask_t write0_tile_mask;
  rrf_tile_mask_t write1_tile_mask;
  rrf_tile_mask_t write2_tile_mask;
  rrf_entry_t     write0_entry;
  rrf_entry_t     write1_entry;
  rrf_entry_t     write2_entry;
  logic           read_thread_q;
  rrf_entry_t     read0_entry;
  rrf_entry_t     read1_entry;
  rrf_entry_t     read2_entry;
  rrf_entry_t     read3_entry;
  rrf_data_t      bank0_read0_data;
  rrf_data_t      bank0_read1_data;
  rrf_data_t      bank0_read2_data;
  rrf_data_t      bank0_read3_data;
  rrf_data_t      bank1_read0_data;
  rrf_data_t      bank1_read1_data;
  rrf_data_t      bank1_read2_data;
  rrf_data_t      bank1_read3_data;

  // Entry index goes to every bank.
  assign write0_entry = write0_addr[RRF_ENTRY_BITS-1:0];
  assign write1_entry = write1_addr[RRF_ENTRY_BITS-1:0];
  assign write2_entry = write2_addr[RRF_ENTRY_BITS-1:0];

  rrf_write_decode write_decode_i (
    .write0_addr      (write0_addr),
    .write1_addr      (write1_addr),
    .write2_addr      (write2_addr),
    .write0_wen       (write0_wen),
    .write1_wen       (write1_wen),
    .write2_wen       (write2_wen),
    .write0_tile_mask (write0_tile_mask),
    .write1_tile_mask (write1_tile_mask),
    .write2_tile_mask (write2_tile_mask)
  );

  rrf_bank bank0_i (
    .clk (clk), .rst (rst),
    .write0_entry (write0_entry), .write1_entry (write1_entry), .write2_entry (write2_entry),
    .write0_data (write0_data), .write1_data (write1_data), .write2_data (write2_data),
    .write0_en (write0_tile_mask[0]), .write1_en (write1_tile_mask[0]),
    .write2_en (write2_tile_mask[0]),
    .write_thread (write_thread), .read_thread (read_thread_q),
    .read0_entry (read0_entry), .read1_entry (read1_entry),
    .read2_entry (read2_entry), .read3_entry (read3_entry),
    .read0_data (bank0_read0_data), .read1_data (bank0_read1_data),
    .read2_data (bank0_read2_data), .read3_data (bank0_read3_data)
  );

  rrf_bank bank1_i (
    .clk (clk), .rst (rst),
    .write0_entry (write0_entry), .write1_entry (write1_entry), .write2_entry (write2_entry),
    .write0_data (write0_data), .write1_data (write1_data), .write2_data (write2_data),
    .write0_en (write0_tile_mask[1]), .write1_en (write1_tile_mask[1]),
    .write2_en (write2_tile_mask[1]),
    .write_thread (write_thread), .read_thread (read_thread_q),
    .read0_entry (read0_entry), .read1_entry (read1_entry),
    .read2_entry (read2_entry), .read3_entry (read3_entry),
    .read0_data (bank1_read0_data), .read1_data (bank1_read1_data),
    .read2_data (bank1_read2_data), .read3_data (bank1_read3_data)
  );

  rrf_read_stage read_stage_i (
    .clk (clk), .rst (rst), .read_clk_en (read_clk_en), .read_thread (read_thread),
    .read0_addr (read0_addr), .read1_addr (read1_addr),
    .read2_addr (read2_addr), .read3_addr (read3_addr),
    .read0_oe (read0_oe), .read1_oe (read1_oe), .read2_oe (read2_oe), .read3_oe (read3_oe),
    .read_thread_q (read_thread_q),
    .read0_entry (read0_entry), .read1_entry (read1_entry),
    .read2_entry (read2_entry), .read3_entry (read3_entry),
    .bank0_read0_data (bank0_read0_data), .bank0_read1_data (bank0_read1_data),
    .bank0_read2_data (bank0_read2_data), .bank0_read3_data (bank0_read3_data),
    .bank1_read0_data (bank1_read0_data), .bank1_read1_data (bank1_read1_data),
    .bank1_read2_data (bank1_read2_data), .bank1_read3_data (bank1_read3_data),
    .read0_data (read0_data), .read1_data (read1_data),
    .read2_data (read2_data), .read3_data (read3_data)
  );

endmodule

// File: rrf_write_decode.sv
`timescale 1ns/100ps

module rrf_write_decode (
  input  rrf_pkg::rrf_addr_t      write0_addr,
  input  rrf_pkg::rrf_addr_t      write1_addr,
  input  rrf_pkg::rrf_addr_t      write2_addr,
  input  logic                    write0_wen,
  input  logic                    write1_wen,
  input  logic                    write2_wen,
  output rrf_pkg::rrf_tile_mask_t write0_tile_mask,
  output rrf_pkg::rrf_tile_mask_t write1_tile_mask,
  output rrf_pkg::rrf_tile_mask_t write2_tile_mask
);

  import rrf_pkg::*;

  rrf_addr_t                  addr [RRF_WRITE_PORTS];
  logic [RRF_WRITE_PORTS-1:0] wen;
  rrf_tile_mask_t             mask [RRF_WRITE_PORTS];

  assign addr[0] = write0_addr;
  assign addr[1] = write1_addr;
  assign addr[2] = write2_addr;

  assign wen = {write2_wen, write1_wen, write0_wen};

  // Lowest port wins on a shared address.
  always_comb
  begin
    logic      shadowed;
    rrf_tile_t tile;
    for (int p = 0; p < RRF_WRITE_PORTS; p++)
    begin
      shadowed = 1'b0;
      tile = addr[p][RRF_ADDR_WIDTH-1:RRF_ENTRY_BITS];
      for (int q = 0; q < p; q++)
      begin
        if (wen[q] && addr[q] == addr[p])
          shadowed = 1'b1;
      end
      // Out-of-range tile leaves the mask empty.
      for (int t = 0; t < RRF_TILE_COUNT; t++)
      begin
        mask[p][t] = wen[p] && !shadowed && tile == rrf_tile_t'(t);
      end
    end
  end

  assign write0_tile_mask = mask[0];
  assign write1_tile_mask = mask[1];
  assign write2_tile_mask = mask[2];

endmodule

// File: tb_rrf_top.sv
`timescale 1ns/100ps

module tb_rrf_top;

  import rrf_pkg::*;

  localparam int RANDOM_CYCLES = 600;
  localparam int WAIT_LIMIT = 20;
  localparam int ADDR_COUNT = 2 ** RRF_ADDR_WIDTH;

  logic        clk;
  logic        rst;
  logic        read_clk_en;
  logic        read_thread;
  rrf_addr_t   read_addr [RRF_READ_PORTS];
  logic        read_oe [RRF_READ_PORTS];
  rrf_data_t   read0_data;
  rrf_data_t   read1_data;
  rrf_data_t   read2_data;
  rrf_data_t   read3_data;
  logic        write_thread;
  rrf_addr_t   write_addr [RRF_WRITE_PORTS];
  rrf_data_t   write_data [RRF_WRITE_PORTS];
  logic        write_wen [RRF_WRITE_PORTS];

  // Reference model of storage and of the read request registers.
  rrf_data_t   model_mem [ADDR_COUNT][RRF_THREADS];
  rrf_addr_t   req_addr [RRF_READ_PORTS];
  logic        req_oe [RRF_READ_PORTS];
  logic        req_thread;

  logic [31:0] lfsr_state;
  int          checks;
  int          errors;
  int          timeouts;

  rrf_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .read_clk_en  (read_clk_en),
    .read_thread  (read_thread),
    .read0_addr   (read_addr[0]),
    .read1_addr   (read_addr[1]),
    .read2_addr   (read_addr[2]),
    .read3_addr   (read_addr[3]),
    .read0_oe     (read_oe[0]),
    .read1_oe     (read_oe[1]),
    .read2_oe     (read_oe[2]),
    .read3_oe     (read_oe[3]),
    .read0_data   (read0_data),
    .read1_data   (read1_data),
    .read2_data   (read2_data),
    .read3_data   (read3_data),
    .write_thread (write_thread),
    .write0_addr  (write_addr[0]),
    .write1_addr  (write_addr[1]),
    .write2_addr  (write_addr[2]),
    .write0_data  (write_data[0]),
    .write1_data  (write_data[1]),
    .write2_data  (write_data[2]),
    .write0_wen   (write_wen[0]),
    .write1_wen   (write_wen[1]),
    .write2_wen   (write_wen[2])
  );

  always #10 clk = ~clk;

  // Galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // A quarter of the picks land on four hot addresses.
  function automatic rrf_addr_t random_addr();
    logic [31:0] pick;
    pick = rand_bits(2);
    if (pick == 0)
      return rrf_addr_t'(rand_bits(2));
    return rrf_addr_t'(rand_bits(RRF_ADDR_WIDTH));
  endfunction

  function automatic logic in_range(input rrf_addr_t a);
    return a[RRF_ADDR_WIDTH-1:RRF_ENTRY_BITS] < rrf_tile_t'(RRF_TILE_COUNT);
  endfunction

  function automatic rrf_data_t expected_read(input int p);
    if (!req_oe[p] || !in_range(req_addr[p]))
      return '0;
    return model_mem[req_addr[p]][req_thread];
  endfunction

  // Applies what the DUT sampled at this edge.
  task automatic update_model();
    logic shadowed;
    if (rst)
    begin
      for (int a = 0; a < ADDR_COUNT; a++)
        for (int t = 0; t < RRF_THREADS; t++)
          model_mem[a][t] = '0;
      for (int p = 0; p < RRF_READ_PORTS; p++)
      begin
        req_addr[p] = '0;
        req_oe[p] = 1'b1;
      end
      req_thread = 1'b0;
    end
    else
    begin
      for (int p = 0; p < RRF_WRITE_PORTS; p++)
      begin
        shadowed = 1'b0;
        for (int q = 0; q < p; q++)
          if (write_wen[q] && write_addr[q] == write_addr[p])
            shadowed = 1'b1;
        if (write_wen[p] && !shadowed && in_range(write_addr[p]))
          model_mem[write_addr[p]][write_thread] = write_data[p];
      end
      if (read_clk_en)
      begin
        for (int p = 0; p < RRF_READ_PORTS; p++)
        begin
          req_addr[p] = read_addr[p];
          req_oe[p] = read_oe[p];
        end
        req_thread = read_thread;
      end
    end
  endtask

  task automatic next_edge();
    @(posedge clk);
    update_model();
  endtask

  task automatic check_reads();
    rrf_data_t got [RRF_READ_PORTS];
    rrf_data_t exp;
    @(negedge clk);
    got[0] = read0_data;
    got[1] = read1_data;
    got[2] = read2_data;
    got[3] = read3_data;
    for (int p = 0; p < RRF_READ_PORTS; p++)
    begin
      exp = expected_read(p);
      checks++;
      if (got[p] !== exp)
      begin
        errors++;
        $display("CHECK FAILED: read%0d_data = %h, expected %h (addr %h, thread %h)",
                 p, got[p], exp, req_addr[p], req_thread);
      end
    end
  endtask

  task automatic wait_reads_zero();
    int n;
    n = 0;
    @(negedge clk);
    while ({read0_data, read1_data, read2_data, read3_data} !== '0)
    begin
      n++;
      if (n >= WAIT_LIMIT)
      begin
        timeouts++;
        $display("Timeout: read ports never showed zero after reset");
        return;
      end
      @(negedge clk);
    end
  endtask

  task automatic drive_random();
    logic [31:0] v;
    for (int p = 0; p < RRF_WRITE_PORTS; p++)
    begin
      v = rand_bits(1);
      write_wen[p] <= v[0];
      write_addr[p] <= random_addr();
      write_data[p] <= rand_bits(RRF_DATA_WIDTH);
    end
    v = rand_bits(1);
    write_thread <= v[0];
    for (int p = 0; p < RRF_READ_PORTS; p++)
    begin
      read_addr[p] <= random_addr();
      v = rand_bits(3);
      read_oe[p] <= (v != 0); // Mostly enabled.
    end
    v = rand_bits(1);
    read_thread <= v[0];
    v = rand_bits(2);
    read_clk_en <= (v != 0);
  endtask

  task automatic drive_idle();
    read_clk_en <= 1'b0;
    for (int p = 0; p < RRF_WRITE_PORTS; p++)
      write_wen[p] <= 1'b0;
  endtask

  initial
  begin
    logic [31:0] v;
    rrf_addr_t   a;
    lfsr_state = 32'h4bb5_3669;
    checks = 0;
    errors = 0;
    timeouts = 0;
    clk = 1'b0;
    rst = 1'b1;
    read_clk_en = 1'b0;
    read_thread = 1'b0;
    write_thread = 1'b0;
    for (int p = 0; p < RRF_READ_PORTS; p++)
    begin
      read_addr[p] = '0;
      read_oe[p] = 1'b1;
    end
    for (int p = 0; p < RRF_WRITE_PORTS; p++)
    begin
      write_addr[p] = '0;
      write_data[p] = '0;
      write_wen[p] = 1'b0;
    end

    for (int i = 0; i < 4; i++)
      next_edge();
    rst <= 1'b0;
    wait_reads_zero();

    // Reads only, nothing written yet.
    for (int i = 0; i < 8; i++)
    begin
      next_edge();
      drive_random();
      for (int p = 0; p < RRF_WRITE_PORTS; p++)
        write_wen[p] <= 1'b0;
      check_reads();
    end

    for (int i = 0; i < RANDOM_CYCLES; i++)
    begin
      next_edge();
      drive_random();
      check_reads();
    end

    // Frozen request, writes aimed at the held addresses.
    for (int i = 0; i < 40; i++)
    begin
      next_edge();
      drive_random();
      v = rand_bits(2);
      read_clk_en <= 1'b0;
      write_wen[0] <= 1'b1;
      write_addr[0] <= req_addr[v[1:0]];
      write_thread <= req_thread;
      check_reads();
    end

    // Output enables low.
    for (int i = 0; i < 20; i++)
    begin
      next_edge();
      drive_random();
      read_clk_en <= 1'b1;
      for (int p = 0; p < RRF_READ_PORTS; p++)
        read_oe[p] <= 1'b0;
      check_reads();
    end

    // Tile fields 2 and 3.
    for (int i = 0; i < 30; i++)
    begin
      next_edge();
      drive_random();
      for (int p = 0; p < RRF_WRITE_PORTS; p++)
      begin
        write_wen[p] <= 1'b1;
        write_addr[p] <= random_addr() | 6'h20;
      end
      read_addr[0] <= random_addr() | 6'h20;
      read_addr[1] <= random_addr() | 6'h20;
      check_reads();
    end

    // All write ports on one address and thread.
    for (int i = 0; i < 30; i++)
    begin
      next_edge();
      drive_random();
      a = random_addr() & 6'h1f;
      v = rand_bits(1);
      for (int p = 0; p < RRF_WRITE_PORTS; p++)
      begin
        write_wen[p] <= 1'b1;
        write_addr[p] <= a;
      end
      write_thread <= v[0];
      read_thread <= v[0];
      read_clk_en <= 1'b1;
      read_addr[0] <= a;
      read_oe[0] <= 1'b1;
      check_reads();
    end

    // Sweep every in-range address for both threads.
    for (int t = 0; t < RRF_THREADS; t++)
    begin
      for (int base = 0; base < RRF_TILE_COUNT * RRF_ENTRIES_PER_TILE; base += 4)
      begin
        next_edge();
        drive_idle();
        read_clk_en <= 1'b1;
        read_thread <= t[0];
        for (int p = 0; p < RRF_READ_PORTS; p++)
        begin
          read_addr[p] <= rrf_addr_t'(base + p);
          read_oe[p] <= 1'b1;
        end
        check_reads();
      end
    end
    next_edge();
    drive_idle();
    check_reads();

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
